//--- alu_exec_unit.f
hdl/alu_pkg.sv
hdl/alu.sv
hdl/alu_writeback.sv
hdl/alu_axil_regs.sv
hdl/alu_exec_unit.sv
verification/tb_clock_gen.sv
verification/tb_alu_exec_unit.sv

//--- Makefile
TB_TOP = tb_alu_exec_unit

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module alu_exec_unit -f alu_exec_unit.f

sim:
	verilator --binary --timing -j 0 --top-module $(TB_TOP) -f alu_exec_unit.f
	out="$$(./obj_dir/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

//--- verification/tb_alu_exec_unit.sv
module tb_alu_exec_unit;
    timeunit 1ns;
    timeprecision 1ps;
    import alu_pkg::*;

    localparam int          TIMEOUT_CYCLES = 50;
    localparam logic [15:0] WRITABLE_BITS  = 16'h0FD5; // Bits 0, 2, 4, 6 to 11
    localparam logic [15:0] FIXED_ONE_BITS = 16'h0002;

    typedef struct packed {
        logic        wr_result;
        logic [15:0] result;
        logic [15:0] flags;
    } ref_out_t;

    logic        clk;
    logic        reset;
    axil_req_t   req;
    axil_rsp_t   rsp;
    logic [15:0] model_result;
    logic [15:0] model_flags;
    integer      seed;

    tb_clock_gen clock_gen_inst (
        .clk   (clk),
        .reset (reset)
    );

    alu_exec_unit #(
        .ADDR_W (5)
    ) alu_exec_unit_inst (
        .clk        (clk),
        .reset      (reset),
        .s_axil_req (req),
        .s_axil_rsp (rsp)
    );

    task automatic fail_test(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp) begin
            fail_test($sformatf("MISMATCH %s expected 0x%h actual 0x%h", name, exp, act));
        end
    endtask

    // Whole flags word, fixed and unwritable bits included
    task automatic check_flags(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp) begin
            fail_test($sformatf("MISMATCH %s expected 0x%h actual 0x%h", name, exp, act));
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            fail_test($sformatf("MISMATCH %s expected 0x%h actual 0x%h", name, exp, act));
        end
    endtask

    function automatic ref_out_t ref_alu(input logic [15:0] a, input logic [15:0] b,
                                         input logic [15:0] flags, input alu_ctrl_t ctrl);
        ref_out_t    r;
        logic [15:0] x;
        logic [15:0] y;
        logic        c;
        logic [16:0] wide;
        logic [8:0]  low;
        logic [15:0] res;
        logic        cf;
        logic        of;
        logic        sign_x;
        logic        sign_y;
        logic        sign_r;
        r.wr_result = 1'b1;
        r.result    = '0;
        r.flags     = flags;
        c    = (ctrl.op inside {ADC, SBB, SBBREV}) ? flags[CF_IDX] : 1'b0;
        x    = (ctrl.op inside {SUBREV, SBBREV}) ? b : a;
        y    = (ctrl.op inside {SUBREV, SBBREV}) ? a : b;
        wide = '0;
        low  = '0;
        res  = '0;
        cf   = 1'b0;
        of   = 1'b0;
        case (ctrl.op)
            SELA:      r.result = a;
            SELB:      r.result = b;
            GETFLAGS:  r.result = flags;
            SETFLAGSB: r.wr_result = 1'b0;
            AND:       res = a & b;
            XOR:       res = a ^ b;
            OR:        res = a | b;
            ADD, ADC: begin
                wide = {1'b0, x} + {1'b0, y} + {16'b0, c};
                low  = {1'b0, x[7:0]} + {1'b0, y[7:0]} + {8'b0, c};
                res  = wide[15:0];
            end
            default: begin // Subtract family
                wide = {1'b0, x} - {1'b0, y} - {16'b0, c};
                low  = {1'b0, x[7:0]} - {1'b0, y[7:0]} - {8'b0, c};
                res  = wide[15:0];
            end
        endcase
        sign_x = ctrl.is_8_bit ? x[7] : x[15];
        sign_y = ctrl.is_8_bit ? y[7] : y[15];
        sign_r = ctrl.is_8_bit ? res[7] : res[15];
        if (ctrl.op inside {ADD, ADC}) begin
            cf = ctrl.is_8_bit ? low[8] : wide[16];
            of = (sign_x == sign_y) && (sign_r != sign_x);
        end else if (ctrl.op inside {SUB, SUBREV, SBB, SBBREV}) begin
            cf = ctrl.is_8_bit ? low[8] : wide[16]; // Borrow out
            of = (sign_x != sign_y) && (sign_r != sign_x);
        end
        if (ctrl.op == SETFLAGSB) begin
            r.flags = (b & WRITABLE_BITS) | FIXED_ONE_BITS;
        end else if (!(ctrl.op inside {SELA, SELB, GETFLAGS})) begin
            r.result        = res;
            r.flags[CF_IDX] = cf;
            r.flags[PF_IDX] = ($countones(res[7:0]) % 2) == 0;
            r.flags[AF_IDX] = a[4] ^ b[4] ^ res[4];
            r.flags[ZF_IDX] = ctrl.is_8_bit ? (res[7:0] == 8'h00) : (res == 16'h0000);
            r.flags[SF_IDX] = sign_r;
            r.flags[OF_IDX] = of;
            r.flags         = (r.flags & WRITABLE_BITS) | FIXED_ONE_BITS;
        end
        return r;
    endfunction

    task automatic axil_write(input logic [4:0] addr, input logic [31:0] data,
                              input int stall, output logic [1:0] resp);
        int cycles;
        @(posedge clk);
        req.awvalid <= 1'b1;
        req.awaddr  <= addr;
        req.wvalid  <= 1'b1;
        req.wdata   <= data;
        req.bready  <= (stall == 0);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                fail_test("write address and data were never accepted");
            end
        end while (!rsp.awready);
        if (rsp.wready !== 1'b1) begin
            fail_test("wready did not rise together with awready");
        end
        @(posedge clk);
        req.awvalid <= 1'b0;
        req.wvalid  <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                fail_test("write response never arrived");
            end
        end while (!rsp.bvalid);
        resp = rsp.bresp;
        repeat (stall) begin
            @(negedge clk);
            if (!rsp.bvalid) begin
                fail_test("bvalid dropped while bready was low");
            end
            check_resp("bresp", resp, rsp.bresp);
        end
        if (stall > 0) begin
            @(posedge clk);
            req.bready <= 1'b1;
        end
        @(posedge clk);
        req.bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [4:0] addr, input int stall,
                             output logic [1:0] resp, output logic [31:0] data);
        int cycles;
        @(posedge clk);
        req.arvalid <= 1'b1;
        req.araddr  <= addr;
        req.rready  <= (stall == 0);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                fail_test("read address was never accepted");
            end
        end while (!rsp.arready);
        @(posedge clk);
        req.arvalid <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                fail_test("read data never arrived");
            end
        end while (!rsp.rvalid);
        resp = rsp.rresp;
        data = rsp.rdata;
        repeat (stall) begin
            @(negedge clk);
            if (!rsp.rvalid) begin
                fail_test("rvalid dropped while rready was low");
            end
            check_resp("rresp", resp, rsp.rresp);
            check_word("rdata_hi", data[31:16], rsp.rdata[31:16]);
            check_word("rdata", data[15:0], rsp.rdata[15:0]);
        end
        if (stall > 0) begin
            @(posedge clk);
            req.rready <= 1'b1;
        end
        @(posedge clk);
        req.rready <= 1'b0;
    endtask

    task automatic check_state();
        logic [1:0]  resp;
        logic [31:0] data;
        axil_read(REG_RESULT, 0, resp, data);
        check_resp("rresp", RESP_OKAY, resp);
        check_word("result", model_result, data[15:0]);
        axil_read(REG_FLAGS, 0, resp, data);
        check_resp("rresp", RESP_OKAY, resp);
        check_flags("flags", model_flags, data[15:0]);
    endtask

    // One operation through the bus, then both registers read back
    task automatic run_op(input logic [15:0] a_val, input logic [15:0] b_val,
                          input alu_op_e op, input logic is8);
        alu_ctrl_t  ctrl;
        ref_out_t   ref_val;
        logic [1:0] resp;
        ctrl.op       = op;
        ctrl.is_8_bit = is8;
        ref_val = ref_alu(a_val, b_val, model_flags, ctrl);
        axil_write(REG_A, {16'b0, a_val}, 0, resp);
        check_resp("bresp", RESP_OKAY, resp);
        axil_write(REG_B, {16'b0, b_val}, 0, resp);
        check_resp("bresp", RESP_OKAY, resp);
        axil_write(REG_CTRL, {23'b0, is8, 4'b0, op}, 0, resp);
        check_resp("bresp", RESP_OKAY, resp);
        if (ref_val.wr_result) begin
            model_result = ref_val.result;
        end
        model_flags = ref_val.flags;
        check_state();
    endtask

    initial begin
        logic [1:0]  resp;
        logic [31:0] data;
        int          cycles;
        logic [15:0] ra;
        logic [15:0] rb;
        logic [3:0]  rop;
        seed = 32'had8a_8b92;
        req <= '0;
        model_result = 16'h0000;
        model_flags  = FIXED_ONE_BITS;
        cycles = 0;
        while (reset !== 1'b0) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                fail_test("reset was never released");
            end
        end
        check_state();

        run_op(16'hFFFF, 16'h0001, ADD, 1'b0);
        run_op(16'h7FFF, 16'h0001, ADD, 1'b0);
        run_op(16'h0000, 16'h0001, SUB, 1'b0);
        run_op(16'h1234, 16'h0001, ADC, 1'b0); // Carry from the borrow above
        run_op(16'hFFFF, 16'hFFFF, ADD, 1'b0);
        run_op(16'h0005, 16'h0003, SBB, 1'b0);

        // Byte width, carry and overflow from bits 8 and 7
        run_op(16'h12FF, 16'h0001, ADD, 1'b1);
        run_op(16'h0040, 16'h0040, ADC, 1'b1);
        run_op(16'h007F, 16'h0001, ADD, 1'b1);
        run_op(16'h0000, 16'h0001, SUB, 1'b1);
        run_op(16'h0080, 16'h0001, SBB, 1'b1);
        run_op(16'h0030, 16'h0010, SUBREV, 1'b1);
        run_op(16'h0001, 16'h0080, SBBREV, 1'b1);

        run_op(16'h8000, 16'h8000, ADD, 1'b0); // Leaves CF and OF set
        run_op(16'hF0F0, 16'h0F0F, AND, 1'b0);
        run_op(16'h8000, 16'h8000, ADD, 1'b0);
        run_op(16'h8001, 16'h0000, XOR, 1'b0);
        run_op(16'h8000, 16'h8000, ADD, 1'b0);
        run_op(16'h0300, 16'h0003, OR, 1'b1);
        run_op(16'h8000, 16'h8000, ADD, 1'b0);
        run_op(16'hA5A5, 16'h5A5A, SELA, 1'b0);
        run_op(16'hA5A5, 16'h5A5A, SELB, 1'b0);
        run_op(16'h0000, 16'h0000, GETFLAGS, 1'b0);

        axil_write(REG_FLAGS, 32'hFFFF_FFFF, 0, resp);
        check_resp("bresp", RESP_OKAY, resp);
        model_flags = 16'h0FD7;
        check_state();
        run_op(16'h0000, 16'h0000, GETFLAGS, 1'b0);
        run_op(16'h0000, 16'hF02A, SETFLAGSB, 1'b0);
        run_op(16'h0000, 16'h0000, GETFLAGS, 1'b0);

        repeat (200) begin
            ra  = 16'($random(seed));
            rb  = 16'($random(seed));
            rop = 4'($unsigned($random(seed)) % 13);
            run_op(ra, rb, alu_op_e'(rop), 1'($random(seed)));
        end

        // Refused writes leave both registers alone
        axil_write(REG_CTRL, 32'h0000_000D, 0, resp);
        check_resp("bresp", RESP_SLVERR, resp);
        check_state();
        axil_write(REG_RESULT, 32'h0000_BEEF, 0, resp);
        check_resp("bresp", RESP_SLVERR, resp);
        check_state();
        axil_read(5'h14, 0, resp, data);
        check_resp("rresp", RESP_SLVERR, resp);
        check_word("rdata_hi", 16'h0000, data[31:16]);
        check_word("rdata", 16'h0000, data[15:0]);

        axil_write(REG_A, 32'h0000_C3A5, 4, resp);
        check_resp("bresp", RESP_OKAY, resp);
        axil_read(REG_A, 4, resp, data);
        check_resp("rresp", RESP_OKAY, resp);
        check_word("rdata", 16'hC3A5, data[15:0]);

        $display("All tests passed");
        $finish;
    end

endmodule

//--- verification/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset is seen on the first two rising edges
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- hdl/alu_exec_unit.sv
module alu_exec_unit #(
    parameter int ADDR_W = 5
) (
    input  logic               clk,
    input  logic               reset,
    input  alu_pkg::axil_req_t s_axil_req,
    output alu_pkg::axil_rsp_t s_axil_rsp
);
    import alu_pkg::*;

    logic [15:0] a;
    logic [15:0] b;
    alu_ctrl_t   ctrl;
    logic        launch;
    logic        flags_wr;
    logic [15:0] flags_wdata;
    logic [15:0] result;
    logic [15:0] flags;
    logic [15:0] alu_out;
    logic [15:0] alu_flags;

    alu_axil_regs #(
        .ADDR_W (ADDR_W)
    ) alu_axil_regs_inst (
        .clk         (clk),
        .reset       (reset),
        .s_axil_req  (s_axil_req),
        .s_axil_rsp  (s_axil_rsp),
        .a           (a),
        .b           (b),
        .ctrl        (ctrl),
        .launch      (launch),
        .flags_wr    (flags_wr),
        .flags_wdata (flags_wdata),
        .result      (result),
        .flags       (flags)
    );

    alu alu_inst (
        .a         (a),
        .b         (b),
        .flags_in  (flags),
        .ctrl      (ctrl),
        .out       (alu_out),
        .flags_out (alu_flags)
    );

    alu_writeback alu_writeback_inst (
        .clk         (clk),
        .reset       (reset),
        .launch      (launch),
        .op          (ctrl.op),
        .alu_out     (alu_out),
        .alu_flags   (alu_flags),
        .flags_wr    (flags_wr),
        .flags_wdata (flags_wdata),
        .result      (result),
        .flags       (flags)
    );

endmodule

//--- hdl/alu_axil_regs.sv
module alu_axil_regs #(
    parameter int ADDR_W = 5
) (
    input  logic               clk,
    input  logic               reset,
    input  alu_pkg::axil_req_t s_axil_req,
    output alu_pkg::axil_rsp_t s_axil_rsp,
    output logic [15:0]        a,
    output logic [15:0]        b,
    output alu_pkg::alu_ctrl_t ctrl,
    output logic               launch,
    output logic               flags_wr,
    output logic [15:0]        flags_wdata,
    input  logic [15:0]        result,
    input  logic [15:0]        flags
);
    import alu_pkg::*;

    logic              active;     // Low through reset
    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;
    logic              wr_accept;
    logic              rd_accept;
    logic [3:0]        wr_op_code;
    logic              wr_op_ok;
    alu_ctrl_t         wr_ctrl;
    alu_ctrl_t         ctrl_q;
    logic [1:0]        wr_resp;
    logic [1:0]        rd_resp;
    logic [31:0]       rd_data;
    logic              bvalid;
    logic [1:0]        bresp;
    logic              rvalid;
    logic [31:0]       rdata;
    logic [1:0]        rresp;

    assign wr_addr = s_axil_req.awaddr;
    assign rd_addr = s_axil_req.araddr;

    // AW and W are taken together, one write at a time
    assign wr_accept = active && !bvalid && s_axil_req.awvalid && s_axil_req.wvalid;
    assign rd_accept = active && !rvalid && s_axil_req.arvalid;

    assign wr_op_code       = s_axil_req.wdata[CTRL_OP_MSB:CTRL_OP_LSB];
    assign wr_op_ok         = wr_op_code <= 4'(SETFLAGSB);
    assign wr_ctrl.op       = alu_op_e'(wr_op_code);
    assign wr_ctrl.is_8_bit = s_axil_req.wdata[CTRL_W8_BIT];

    always_comb begin
        launch   = 1'b0;
        flags_wr = 1'b0;
        wr_resp  = RESP_OKAY;
        case (wr_addr)
            REG_A, REG_B: wr_resp = RESP_OKAY;
            REG_CTRL: begin
                if (wr_op_ok) begin
                    launch = wr_accept;
                end else begin
                    wr_resp = RESP_SLVERR; // Unassigned opcode
                end
            end
            REG_FLAGS: flags_wr = wr_accept;
            default:   wr_resp  = RESP_SLVERR; // RESULT is read-only
        endcase
    end

    assign flags_wdata = s_axil_req.wdata[15:0];

    // ALU sees the new control word during the launch cycle
    assign ctrl = launch ? wr_ctrl : ctrl_q;

    always_comb begin
        rd_data = '0;
        rd_resp = RESP_OKAY;
        case (rd_addr)
            REG_A:      rd_data = {16'b0, a};
            REG_B:      rd_data = {16'b0, b};
            REG_CTRL:   rd_data = {23'b0, ctrl_q.is_8_bit, 4'b0, ctrl_q.op};
            REG_RESULT: rd_data = {16'b0, result};
            REG_FLAGS:  rd_data = {16'b0, flags};
            default:    rd_resp = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            a      <= '0;
            b      <= '0;
            ctrl_q <= '0;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            active <= 1'b1;
            if (wr_accept) begin
                bvalid <= 1'b1;
                if (wr_addr == REG_A) begin
                    a <= s_axil_req.wdata[15:0];
                end
                if (wr_addr == REG_B) begin
                    b <= s_axil_req.wdata[15:0];
                end
                if (launch) begin
                    ctrl_q <= wr_ctrl;
                end
            end else if (bvalid && s_axil_req.bready) begin
                bvalid <= 1'b0;
            end
            if (rd_accept) begin
                rvalid <= 1'b1;
            end else if (rvalid && s_axil_req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Response payload, held while valid is up
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            bresp <= wr_resp;
        end
        if (rd_accept) begin
            rdata <= rd_data;
            rresp <= rd_resp;
        end
    end

    assign s_axil_rsp.awready = wr_accept;
    assign s_axil_rsp.wready  = wr_accept;
    assign s_axil_rsp.bvalid  = bvalid;
    assign s_axil_rsp.bresp   = bresp;
    assign s_axil_rsp.arready = rd_accept;
    assign s_axil_rsp.rvalid  = rvalid;
    assign s_axil_rsp.rdata   = rdata;
    assign s_axil_rsp.rresp   = rresp;

endmodule

//--- hdl/alu_writeback.sv
module alu_writeback (
    input  logic             clk,
    input  logic             reset,
    input  logic             launch,
    input  alu_pkg::alu_op_e op,
    input  logic [15:0]      alu_out,
    input  logic [15:0]      alu_flags,
    input  logic             flags_wr,
    input  logic [15:0]      flags_wdata,
    output logic [15:0]      result,
    output logic [15:0]      flags
);
    import alu_pkg::*;

    logic wr_result;
    logic wr_flags;

    function automatic logic [15:0] mask_flags(input logic [15:0] f);
        return (f & FLAGS_WRITABLE) | FLAGS_FIXED_ONE;
    endfunction

    // Which registers an opcode updates
    always_comb begin
        case (op)
            SELA, SELB, GETFLAGS: begin
                wr_result = 1'b1;
                wr_flags  = 1'b0;
            end
            SETFLAGSB: begin
                wr_result = 1'b0;
                wr_flags  = 1'b1;
            end
            ADD, ADC, AND, XOR, OR, SUB, SUBREV, SBB, SBBREV: begin
                wr_result = 1'b1;
                wr_flags  = 1'b1;
            end
            default: begin
                wr_result = 1'b0;
                wr_flags  = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
            flags  <= FLAGS_FIXED_ONE;
        end else begin
            if (launch && wr_result) begin
                result <= alu_out;
            end
            if (launch && wr_flags) begin
                flags <= mask_flags(alu_flags);
            end else if (flags_wr) begin
                flags <= mask_flags(flags_wdata); // Host write
            end
        end
    end

endmodule

//--- hdl/alu.sv
module alu (
    input  logic [15:0]        a,
    input  logic [15:0]        b,
    input  logic [15:0]        flags_in,
    input  alu_pkg::alu_ctrl_t ctrl,
    output logic [15:0]        out,
    output logic [15:0]        flags_out
);
    import alu_pkg::*;

    logic [15:0] op_x;
    logic [15:0] op_y;
    logic        carry_in;
    logic [16:0] sum;
    logic [16:0] diff;
    logic        add_cf;
    logic        add_of;
    logic        sub_cf;
    logic        sub_of;
    logic        cf;
    logic        of;

    // Operand order and carry-in per opcode
    always_comb begin
        op_x     = a;
        op_y     = b;
        carry_in = 1'b0;
        case (ctrl.op)
            ADC, SBB: begin
                carry_in = flags_in[CF_IDX];
            end
            SUBREV: begin
                op_x = b;
                op_y = a;
            end
            SBBREV: begin
                op_x     = b;
                op_y     = a;
                carry_in = flags_in[CF_IDX];
            end
            default: begin
                carry_in = 1'b0;
            end
        endcase
    end

    assign sum  = {1'b0, op_x} + {1'b0, op_y} + {16'b0, carry_in};
    assign diff = {1'b0, op_x} - {1'b0, op_y} - {16'b0, carry_in};

    // Byte ops take carry out of bit 7 as the carry into bit 8
    always_comb begin
        if (ctrl.is_8_bit) begin
            add_cf = op_x[8] ^ op_y[8] ^ sum[8];
            add_of = ~(op_x[7] ^ op_y[7]) & (sum[7] ^ op_y[7]);
            sub_cf = op_x[8] ^ op_y[8] ^ diff[8];
            sub_of = (op_x[7] ^ op_y[7]) & (diff[7] ^ op_x[7]);
        end else begin
            add_cf = sum[16];
            add_of = ~(op_x[15] ^ op_y[15]) & (sum[15] ^ op_y[15]);
            sub_cf = diff[16]; // Borrow
            sub_of = (op_x[15] ^ op_y[15]) & (diff[15] ^ op_x[15]);
        end
    end

    always_comb begin
        out = a;
        cf  = flags_in[CF_IDX];
        of  = flags_in[OF_IDX];
        case (ctrl.op)
            SELA: out = a;
            SELB: out = b;
            ADD, ADC: begin
                out = sum[15:0];
                cf  = add_cf;
                of  = add_of;
            end
            SUB, SUBREV, SBB, SBBREV: begin
                out = diff[15:0];
                cf  = sub_cf;
                of  = sub_of;
            end
            AND, XOR, OR: begin
                if (ctrl.op == AND) begin
                    out = a & b;
                end else if (ctrl.op == XOR) begin
                    out = a ^ b;
                end else begin
                    out = a | b;
                end
                cf = 1'b0;
                of = 1'b0;
            end
            GETFLAGS:  out = flags_in;
            SETFLAGSB: out = b;
            default:   out = a; // Never launched
        endcase
    end

    // Status flags follow the result, TF/IF/DF pass through
    always_comb begin
        flags_out         = flags_in;
        flags_out[CF_IDX] = cf;
        flags_out[PF_IDX] = ~^out[7:0];
        flags_out[AF_IDX] = a[4] ^ b[4] ^ out[4];
        flags_out[ZF_IDX] = ctrl.is_8_bit ? ~|out[7:0] : ~|out;
        flags_out[SF_IDX] = ctrl.is_8_bit ? out[7] : out[15];
        flags_out[OF_IDX] = of;
        if (ctrl.op == SETFLAGSB) begin
            flags_out = b;
        end
    end

endmodule

//--- hdl/alu_pkg.sv
package alu_pkg;

    // ALU opcodes, codes 13 to 15 are unassigned
    typedef enum logic [3:0] {
        SELA      = 4'd0,
        SELB      = 4'd1,
        ADD       = 4'd2,
        ADC       = 4'd3,
        AND       = 4'd4,
        XOR       = 4'd5,
        OR        = 4'd6,
        SUB       = 4'd7,
        SUBREV    = 4'd8,
        SBB       = 4'd9,
        SBBREV    = 4'd10,
        GETFLAGS  = 4'd11,
        SETFLAGSB = 4'd12
    } alu_op_e;

    // x86 flag bit positions
    localparam logic [3:0] CF_IDX = 4'd0;
    localparam logic [3:0] PF_IDX = 4'd2;
    localparam logic [3:0] AF_IDX = 4'd4;
    localparam logic [3:0] ZF_IDX = 4'd6;
    localparam logic [3:0] SF_IDX = 4'd7;
    localparam logic [3:0] TF_IDX = 4'd8;
    localparam logic [3:0] IF_IDX = 4'd9;
    localparam logic [3:0] DF_IDX = 4'd10;
    localparam logic [3:0] OF_IDX = 4'd11;

    localparam logic [15:0] FLAGS_FIXED_ONE = 16'h0002; // Bit 1 always set
    localparam logic [15:0] FLAGS_WRITABLE  = 16'h0FD5;

    typedef struct packed {
        alu_op_e op;
        logic    is_8_bit;
    } alu_ctrl_t;

    localparam int AXIL_ADDR_W = 5;

    typedef struct packed {
        logic                   awvalid;
        logic [AXIL_ADDR_W-1:0] awaddr;
        logic                   wvalid;
        logic [31:0]            wdata;
        logic                   bready;
        logic                   arvalid;
        logic [AXIL_ADDR_W-1:0] araddr;
        logic                   rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

    // Register map
    localparam logic [AXIL_ADDR_W-1:0] REG_A      = 5'h00;
    localparam logic [AXIL_ADDR_W-1:0] REG_B      = 5'h04;
    localparam logic [AXIL_ADDR_W-1:0] REG_CTRL   = 5'h08;
    localparam logic [AXIL_ADDR_W-1:0] REG_RESULT = 5'h0C;
    localparam logic [AXIL_ADDR_W-1:0] REG_FLAGS  = 5'h10;

    // CTRL word fields
    localparam int CTRL_OP_LSB = 0;
    localparam int CTRL_OP_MSB = 3;
    localparam int CTRL_W8_BIT = 8;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage
